//--- verification/soc_cases.txt
# name op address value, address and value in hex
# W write, R read, G read at least, S irq sources, L leds, T timer irq level wait, E ext irq
ram_w0 W 20000000 rand
ram_w1 W 20000004 rand
ram_w2 W 200003fc rand
ram_w3 W 20000120 rand
ram_r0 R 20000000 model
ram_r1 R 20000004 model
ram_r2 R 200003fc model
ram_w4 W 20000004 rand
ram_r3 R 20000004 model
ram_r4 R 20000120 model
sys_id R 59000000 3
sys_ram R 59000004 400
sys_freq R 59000008 5f5e100
led_w W 5900000c 1a5
led_out L 0 a5
led_r R 5900000c a5
ro_id_w W 59000000 12345678
ro_id_r R 59000000 3
ro_freq_w W 59000008 0
ro_freq_r R 59000008 5f5e100
tmr_cmp W 55000004 28
tmr_cnt W 55000000 0
tmr_en W 55000008 1
tmr_low T 0 0
tmr_rise T 1 3c
tmr_count G 55000000 28
tmr_dis W 55000008 0
tmr_drop T 0 0
plic_en W 58000004 f
plic_src S 0 a
plic_idle S 0 0
plic_irq E 0 1
plic_claim1 R 58000008 2
plic_done1 W 58000008 1
plic_claim3 R 58000008 4
plic_done3 W 58000008 3
plic_claim0 R 58000008 0
plic_quiet E 0 0
gap_near R 00000010 0
gap_far R 51000000 0
gap_far_w W 51000004 5
after_gap R 59000000 3
ram_after R 20000000 model

//--- tb.f
design/soc_pkg.sv
design/near_bus.sv
design/bus_bridge.sv
design/timer.sv
design/plic.sv
design/system_registers.sv
design/soc_top.sv
verification/tb_soc.sv

//--- verification/tb_soc.sv
`timescale 1ns/100ps
`default_nettype none

module tb_soc
	import soc_pkg::*;
();

	localparam string CASE_FILE = "verification/soc_cases.txt";
	localparam int RESET_CYCLES = 4;
	localparam int CYCLES_PER_CASE = 20;
	localparam int READY_LIMIT = 16;

	logic clock;
	logic rst;
	logic bus_request;
	logic bus_rw;
	logic [ADDR_W-1:0] bus_address;
	logic [DATA_W-1:0] bus_wdata;
	logic [IRQ_SOURCES-1:0] irq_src;
	logic [DATA_W-1:0] bus_rdata;
	logic bus_ready;
	logic [LED_W-1:0] leds;
	logic timer_irq;
	logic ext_irq;

	// Case table, one entry per line of the case file
	string case_name [$];
	string case_op [$];
	logic [ADDR_W-1:0] case_addr [$];
	string case_text [$];

	logic [DATA_W-1:0] ram_model [RAM_WORDS];
	int wait_budget;
	int watchdog_cycles;
	logic cases_loaded;

	soc_top DUT (
		.i_clock(clock),
		.i_rst(rst),
		.i_bus_request(bus_request),
		.i_bus_rw(bus_rw),
		.i_bus_address(bus_address),
		.i_bus_wdata(bus_wdata),
		.i_irq_src(irq_src),
		.o_bus_rdata(bus_rdata),
		.o_bus_ready(bus_ready),
		.o_leds(leds),
		.o_timer_irq(timer_irq),
		.o_ext_irq(ext_irq)
	);

	always #4 clock = ~clock;

	// ====================================================================
	// Helpers

	task automatic fail_run();
		$display("tests failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic load_cases();
		int fd;
		int fields;
		string line;
		string name;
		string op;
		string text;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] value;
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the case file %s", CASE_FILE);
			fail_run();
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// Skip blank lines and column notes
				if (line.len() == 0 || line[0] == "#") continue;
				fields = $sscanf(line, "%s %s %h %s", name, op, addr, text);
				if (fields != 4) continue;
				case_name.push_back(name);
				case_op.push_back(op);
				case_addr.push_back(addr);
				case_text.push_back(text);
				if (op == "T") begin
					void'($sscanf(text, "%h", value));
					wait_budget += int'(value);
				end
			end
			$fclose(fd);
		end
	endtask

	// One strobe, then wait for the single ready pulse
	task automatic bus_access(input string name, input logic rw,
		input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
		output logic [DATA_W-1:0] rdata);
		int latency;
		int expected_latency;
		// Bridge accesses pass the registered bridge, one extra cycle
		expected_latency = (addr[ADDR_W-1 -: 4] == REGION_BRIDGE) ? 2 : 1;
		@(negedge clock);
		bus_request = 1'b1;
		bus_rw = rw;
		bus_address = addr;
		bus_wdata = wdata;
		@(negedge clock);
		bus_request = 1'b0;
		bus_address = '0;
		bus_wdata = '0;
		latency = 1;
		while (bus_ready !== 1'b1 && latency < READY_LIMIT) begin
			@(negedge clock);
			latency++;
		end
		assert (bus_ready === 1'b1) else begin
			$display("No bus ready within %0d cycles in %s", READY_LIMIT, name);
			fail_run();
		end
		rdata = bus_rdata;
		assert (latency == expected_latency) else begin
			$display("Mismatch in %s ready latency: expected %0d, actual %0d",
				name, expected_latency, latency);
			fail_run();
		end
	endtask

	task automatic wait_timer_irq(input string name, input logic level,
		input int max_cycles);
		int waited;
		@(negedge clock);
		waited = 0;
		while (timer_irq !== level && waited < max_cycles) begin
			@(negedge clock);
			waited++;
		end
		assert (timer_irq === level) else begin
			$display("Timer interrupt in %s did not reach %0b within %0d cycles",
				name, level, max_cycles);
			fail_run();
		end
	endtask

	// ====================================================================
	// Case execution

	task automatic run_case(input int i);
		string name;
		string op;
		string text;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] value;
		logic [DATA_W-1:0] rdata;
		logic [RAM_INDEX_W-1:0] index;
		name = case_name[i];
		op = case_op[i];
		text = case_text[i];
		addr = case_addr[i];
		index = addr[RAM_INDEX_W+1:2];
		if (text == "rand") begin
			value = $urandom();
		end else if (text == "model") begin
			value = ram_model[index];
		end else begin
			void'($sscanf(text, "%h", value));
		end
		if (op == "W") begin
			bus_access(name, 1'b1, addr, value, rdata);
			if (addr[ADDR_W-1 -: 4] == REGION_RAM) begin
				ram_model[index] = value;
			end
		end else if (op == "R") begin
			bus_access(name, 1'b0, addr, '0, rdata);
			check_value(name, value, rdata);
		end else if (op == "G") begin
			// Lower bound only, e.g. a running counter
			bus_access(name, 1'b0, addr, '0, rdata);
			assert (rdata >= value) else begin
				$display("Mismatch in %s: expected at least %h, actual %h", name, value, rdata);
				fail_run();
			end
		end else if (op == "S") begin
			@(negedge clock);
			irq_src = value[IRQ_SOURCES-1:0];
		end else if (op == "L") begin
			@(negedge clock);
			check_value(name, value, DATA_W'(leds));
		end else if (op == "E") begin
			@(negedge clock);
			check_value(name, value, DATA_W'(ext_irq));
		end else if (op == "T") begin
			wait_timer_irq(name, addr[0], int'(value));
		end else begin
			$display("Unknown operation %s in case %s", op, name);
			fail_run();
		end
	endtask

	initial begin
		clock = 1'b0;
		rst = 1'b1;
		bus_request = 1'b0;
		bus_rw = 1'b0;
		bus_address = '0;
		bus_wdata = '0;
		irq_src = '0;
		cases_loaded = 1'b0;
		wait_budget = 0;
		void'($urandom(88070));
		load_cases();
		watchdog_cycles = RESET_CYCLES + CYCLES_PER_CASE * case_name.size() + wait_budget;
		cases_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		for (int i = 0; i < case_name.size(); i++) begin
			run_case(i);
		end
		$display("all tests passed");
		$finish;
	end

	// Watchdog
	initial begin
		wait (cases_loaded);
		repeat (watchdog_cycles) @(posedge clock);
		$display("Watchdog expired after %0d cycles", watchdog_cycles);
		fail_run();
	end

endmodule

`default_nettype wire

//--- design/soc_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_top
	import soc_pkg::*;
(
	input wire i_clock,
	input wire i_rst,
	input wire i_bus_request,
	input wire i_bus_rw,
	input wire [ADDR_W-1:0] i_bus_address,
	input wire [DATA_W-1:0] i_bus_wdata,
	input wire [IRQ_SOURCES-1:0] i_irq_src,
	output logic [DATA_W-1:0] o_bus_rdata,
	output logic o_bus_ready,
	output logic [LED_W-1:0] o_leds,
	output logic o_timer_irq,
	output logic o_ext_irq
);

	// Near side to bridge
	wire br_request;
	wire br_rw;
	wire [BR_ADDR_W-1:0] br_address;
	wire [DATA_W-1:0] br_wdata;
	wire [DATA_W-1:0] br_rdata;
	wire br_ready;

	// Far bus
	wire far_rw;
	wire [REG_OFFSET_W-1:0] far_offset;
	wire [DATA_W-1:0] far_wdata;

	wire timer_request;
	wire [DATA_W-1:0] timer_rdata;
	wire timer_ready;
	wire plic_request;
	wire [DATA_W-1:0] plic_rdata;
	wire plic_ready;
	wire sys_request;
	wire [DATA_W-1:0] sys_rdata;
	wire sys_ready;

	near_bus u_near_bus (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_bus_request(i_bus_request),
		.i_bus_rw(i_bus_rw),
		.i_bus_address(i_bus_address),
		.i_bus_wdata(i_bus_wdata),
		.o_bus_rdata(o_bus_rdata),
		.o_bus_ready(o_bus_ready),
		.o_br_request(br_request),
		.o_br_rw(br_rw),
		.o_br_address(br_address),
		.o_br_wdata(br_wdata),
		.i_br_rdata(br_rdata),
		.i_br_ready(br_ready)
	);

	// ====================================================================
	// Bridge and far peripherals

	bus_bridge u_bridge (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(br_request),
		.i_rw(br_rw),
		.i_address(br_address),
		.i_wdata(br_wdata),
		.o_rdata(br_rdata),
		.o_ready(br_ready),
		.o_timer_request(timer_request),
		.o_plic_request(plic_request),
		.o_sys_request(sys_request),
		.o_far_rw(far_rw),
		.o_far_offset(far_offset),
		.o_far_wdata(far_wdata),
		.i_timer_rdata(timer_rdata),
		.i_timer_ready(timer_ready),
		.i_plic_rdata(plic_rdata),
		.i_plic_ready(plic_ready),
		.i_sys_rdata(sys_rdata),
		.i_sys_ready(sys_ready)
	);

	timer u_timer (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(timer_request),
		.i_rw(far_rw),
		.i_offset(far_offset),
		.i_wdata(far_wdata),
		.o_rdata(timer_rdata),
		.o_ready(timer_ready),
		.o_irq(o_timer_irq)
	);

	plic u_plic (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_irq_src(i_irq_src),
		.i_request(plic_request),
		.i_rw(far_rw),
		.i_offset(far_offset),
		.i_wdata(far_wdata),
		.o_rdata(plic_rdata),
		.o_ready(plic_ready),
		.o_irq(o_ext_irq)
	);

	system_registers u_sysreg (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(sys_request),
		.i_rw(far_rw),
		.i_offset(far_offset),
		.i_wdata(far_wdata),
		.o_rdata(sys_rdata),
		.o_ready(sys_ready),
		.o_leds(o_leds)
	);

endmodule

`default_nettype wire

//--- design/system_registers.sv
`timescale 1ns/100ps
`default_nettype none

module system_registers
	import soc_pkg::*;
(
	input wire i_clock,
	input wire i_rst,
	input wire i_request,
	input wire i_rw,
	input wire [REG_OFFSET_W-1:0] i_offset,
	input wire [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic [LED_W-1:0] o_leds
);

	sysreg_e reg_sel;
	logic [LED_W-1:0] leds;

	assign reg_sel = sysreg_e'(i_offset);

	// Only the LED register is writable
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			leds <= '0;
		end else if (i_request && i_rw && reg_sel == SYS_LEDS) begin
			leds <= i_wdata[LED_W-1:0];
		end
	end

	always_comb begin
		case (reg_sel)
			SYS_DEVICE_ID: o_rdata = DEVICE_ID;
			SYS_RAM_SIZE: o_rdata = RAM_BYTES;
			SYS_FREQUENCY: o_rdata = CLOCK_FREQUENCY;
			SYS_LEDS: o_rdata = DATA_W'(leds);
			default: o_rdata = '0;
		endcase
	end

	assign o_ready = i_request;
	assign o_leds = leds;

endmodule

`default_nettype wire

//--- design/plic.sv
`timescale 1ns/100ps
`default_nettype none

module plic
	import soc_pkg::*;
(
	input wire i_clock,
	input wire i_rst,
	input wire [IRQ_SOURCES-1:0] i_irq_src,
	input wire i_request,
	input wire i_rw,
	input wire [REG_OFFSET_W-1:0] i_offset,
	input wire [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_irq
);

	plic_reg_e reg_sel;
	logic write;
	logic [IRQ_SOURCES-1:0] pending;
	logic [IRQ_SOURCES-1:0] enable;
	logic [IRQ_SOURCES-1:0] active;
	logic [IRQ_SOURCES-1:0] clear;
	logic [DATA_W-1:0] claim_id;

	assign reg_sel = plic_reg_e'(i_offset);
	assign write = i_request && i_rw;
	assign active = pending & enable;

	// ====================================================================
	// Claim, lowest active source wins

	always_comb begin
		claim_id = '0;
		for (int i = IRQ_SOURCES - 1; i >= 0; i--) begin
			if (active[i]) begin
				claim_id = DATA_W'(i + 1);
			end
		end
	end

	// Completion, source number written to the claim register
	always_comb begin
		for (int k = 0; k < IRQ_SOURCES; k++) begin
			clear[k] = write && reg_sel == PLIC_CLAIM && i_wdata == DATA_W'(k);
		end
	end

	// A source held high keeps its pending bit set
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			pending <= '0;
			enable <= '0;
		end else begin
			pending <= (pending & ~clear) | i_irq_src;
			if (write && reg_sel == PLIC_ENABLE) begin
				enable <= i_wdata[IRQ_SOURCES-1:0];
			end
		end
	end

	always_comb begin
		case (reg_sel)
			PLIC_PENDING: o_rdata = DATA_W'(pending);
			PLIC_ENABLE: o_rdata = DATA_W'(enable);
			PLIC_CLAIM: o_rdata = claim_id;
			default: o_rdata = '0;
		endcase
	end

	assign o_ready = i_request;
	assign o_irq = |active;

	a_quiet_claim: assert property (@(posedge i_clock) disable iff (i_rst)
		!o_irq |-> (claim_id == '0))
		else $error("Claim value without a pending interrupt");

endmodule

`default_nettype wire

//--- design/timer.sv
`timescale 1ns/100ps
`default_nettype none

module timer
	import soc_pkg::*;
(
	input wire i_clock,
	input wire i_rst,
	input wire i_request,
	input wire i_rw,
	input wire [REG_OFFSET_W-1:0] i_offset,
	input wire [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_irq
);

	timer_reg_e reg_sel;
	logic write;
	logic [DATA_W-1:0] count;
	logic [DATA_W-1:0] compare;
	logic enable;

	assign reg_sel = timer_reg_e'(i_offset);
	assign write = i_request && i_rw;

	// A count write takes priority over the increment
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			count <= '0;
			compare <= '0;
			enable <= 1'b0;
		end else begin
			if (write && reg_sel == TIMER_COUNT) begin
				count <= i_wdata;
			end else if (enable) begin
				count <= count + DATA_W'(1);
			end
			if (write && reg_sel == TIMER_COMPARE) begin
				compare <= i_wdata;
			end
			if (write && reg_sel == TIMER_CONTROL) begin
				enable <= i_wdata[0];
			end
		end
	end

	// Read mux
	always_comb begin
		case (reg_sel)
			TIMER_COUNT: o_rdata = count;
			TIMER_COMPARE: o_rdata = compare;
			TIMER_CONTROL: o_rdata = DATA_W'(enable);
			default: o_rdata = '0;
		endcase
	end

	assign o_ready = i_request;

	// Level interrupt, held until compare moves or the timer stops
	assign o_irq = enable && (count >= compare);

endmodule

`default_nettype wire

//--- design/bus_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module bus_bridge
	import soc_pkg::*;
(
	input wire i_clock,
	input wire i_rst,

	// Near side
	input wire i_request,
	input wire i_rw,
	input wire [BR_ADDR_W-1:0] i_address,
	input wire [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_rdata,
	output logic o_ready,

	// Far side
	output logic o_timer_request,
	output logic o_plic_request,
	output logic o_sys_request,
	output logic o_far_rw,
	output logic [REG_OFFSET_W-1:0] o_far_offset,
	output logic [DATA_W-1:0] o_far_wdata,
	input wire [DATA_W-1:0] i_timer_rdata,
	input wire i_timer_ready,
	input wire [DATA_W-1:0] i_plic_rdata,
	input wire i_plic_ready,
	input wire [DATA_W-1:0] i_sys_rdata,
	input wire i_sys_ready
);

	logic req_q;
	logic rw_q;
	far_dev_e dev_q;
	logic [REG_OFFSET_W-1:0] offset_q;
	logic [DATA_W-1:0] wdata_q;

	logic [DATA_W-1:0] far_rdata;
	logic far_ready;
	logic [DATA_W-1:0] rdata_q;
	logic ready_q;
	logic busy;

	// ====================================================================
	// Near request capture

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			req_q <= 1'b0;
		end else begin
			req_q <= i_request;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_request) begin
			rw_q <= i_rw;
			dev_q <= far_dev_e'(i_address[BR_ADDR_W-1 -: $bits(far_dev_e)]);
			offset_q <= i_address[4:2];
			wdata_q <= i_wdata;
		end
	end

	assign o_far_rw = rw_q;
	assign o_far_offset = offset_q;
	assign o_far_wdata = wdata_q;

	// ====================================================================
	// Device decode and return mux

	always_comb begin
		o_timer_request = 1'b0;
		o_plic_request = 1'b0;
		o_sys_request = 1'b0;
		far_rdata = '0;
		// Unmapped devices answer by themselves
		far_ready = req_q;
		case (dev_q)
			DEV_TIMER: begin
				o_timer_request = req_q;
				far_rdata = i_timer_rdata;
				far_ready = i_timer_ready;
			end
			DEV_PLIC: begin
				o_plic_request = req_q;
				far_rdata = i_plic_rdata;
				far_ready = i_plic_ready;
			end
			DEV_SYSREG: begin
				o_sys_request = req_q;
				far_rdata = i_sys_rdata;
				far_ready = i_sys_ready;
			end
			default: ;
		endcase
	end

	// Registered return towards the near bus
	always_ff @(posedge i_clock) begin
		rdata_q <= (far_ready && !rw_q) ? far_rdata : '0;
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ready_q <= 1'b0;
			busy <= 1'b0;
		end else begin
			ready_q <= far_ready;
			if (i_request) begin
				busy <= 1'b1;
			end else if (ready_q) begin
				busy <= 1'b0;
			end
		end
	end

	assign o_rdata = rdata_q;
	assign o_ready = ready_q;

	a_no_overlap: assert property (@(posedge i_clock) disable iff (i_rst)
		i_request |-> !busy)
		else $error("Near request while bridge busy");

	// Far devices answer in the strobe cycle
	a_far_answer: assert property (@(posedge i_clock) disable iff (i_rst)
		req_q |-> far_ready)
		else $error("Far device did not answer its strobe");

endmodule

`default_nettype wire

//--- design/near_bus.sv
`timescale 1ns/100ps
`default_nettype none

module near_bus
	import soc_pkg::*;
(
	input wire i_clock,
	input wire i_rst,

	// System bus
	input wire i_bus_request,
	input wire i_bus_rw,
	input wire [ADDR_W-1:0] i_bus_address,
	input wire [DATA_W-1:0] i_bus_wdata,
	output logic [DATA_W-1:0] o_bus_rdata,
	output logic o_bus_ready,

	// Bridge port
	output logic o_br_request,
	output logic o_br_rw,
	output logic [BR_ADDR_W-1:0] o_br_address,
	output logic [DATA_W-1:0] o_br_wdata,
	input wire [DATA_W-1:0] i_br_rdata,
	input wire i_br_ready
);

	region_e region;
	logic ram_select;
	logic bridge_select;
	logic unmapped_select;

	logic [RAM_INDEX_W-1:0] ram_index;
	logic [DATA_W-1:0] ram [RAM_WORDS];
	logic [DATA_W-1:0] ram_rdata;
	logic ram_ready;
	logic ram_read;
	logic unmapped_ready;

	// ====================================================================
	// Region decode

	assign region = region_e'(i_bus_address[ADDR_W-1 -: $bits(region_e)]);

	always_comb begin
		ram_select = 1'b0;
		bridge_select = 1'b0;
		unmapped_select = 1'b0;
		case (region)
			REGION_RAM: ram_select = 1'b1;
			REGION_BRIDGE: bridge_select = 1'b1;
			default: unmapped_select = 1'b1;
		endcase
	end

	// ====================================================================
	// Work RAM, word addressed

	assign ram_index = i_bus_address[RAM_INDEX_W+1:2];

	always_ff @(posedge i_clock) begin
		if (i_bus_request && ram_select) begin
			if (i_bus_rw) begin
				ram[ram_index] <= i_bus_wdata;
			end else begin
				ram_rdata <= ram[ram_index];
			end
		end
	end

	// RAM and unmapped answers one cycle after the strobe
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ram_ready <= 1'b0;
			ram_read <= 1'b0;
			unmapped_ready <= 1'b0;
		end else begin
			ram_ready <= i_bus_request && ram_select;
			ram_read <= i_bus_request && ram_select && !i_bus_rw;
			unmapped_ready <= i_bus_request && unmapped_select;
		end
	end

	// Bridge gets the strobe in the same cycle
	assign o_br_request = i_bus_request && bridge_select;
	assign o_br_rw = i_bus_rw;
	assign o_br_address = i_bus_address[BR_ADDR_W-1:0];
	assign o_br_wdata = i_bus_wdata;

	// Return mux, zero outside a read answer
	assign o_bus_ready = ram_ready || unmapped_ready || i_br_ready;
	assign o_bus_rdata = ram_read ? ram_rdata :
		i_br_ready ? i_br_rdata : '0;

	// Only one access is ever in flight
	a_single_return: assert property (@(posedge i_clock) disable iff (i_rst)
		!(ram_ready && i_br_ready))
		else $error("RAM and bridge returned in the same cycle");

endmodule

`default_nettype wire

//--- design/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// ====================================================================
	// Bus widths

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Address bits forwarded across the bridge
	localparam int BR_ADDR_W = 28;

	// Word offset inside a far peripheral, address bits 4 to 2
	localparam int REG_OFFSET_W = 3;

	// ====================================================================
	// Work RAM and system constants

	localparam int RAM_WORDS = 256;
	localparam int RAM_INDEX_W = $clog2(RAM_WORDS);

	localparam logic [DATA_W-1:0] CLOCK_FREQUENCY = 32'd100000000;
	localparam logic [DATA_W-1:0] DEVICE_ID = 32'd3;
	localparam logic [DATA_W-1:0] RAM_BYTES = 32'(RAM_WORDS * 4);

	localparam int IRQ_SOURCES = 4;
	localparam int LED_W = 8;

	// ====================================================================
	// Address decode and register maps

	// Near region, address bits 31 to 28
	typedef enum logic [3:0] {
		REGION_RAM    = 4'h2,
		REGION_BRIDGE = 4'h5
	} region_e;

	// Far device, address bits 27 to 24
	typedef enum logic [3:0] {
		DEV_TIMER  = 4'h5,
		DEV_PLIC   = 4'h8,
		DEV_SYSREG = 4'h9
	} far_dev_e;

	typedef enum logic [REG_OFFSET_W-1:0] {
		TIMER_COUNT   = 3'd0,
		TIMER_COMPARE = 3'd1,
		TIMER_CONTROL = 3'd2
	} timer_reg_e;

	typedef enum logic [REG_OFFSET_W-1:0] {
		PLIC_PENDING = 3'd0,
		PLIC_ENABLE  = 3'd1,
		PLIC_CLAIM   = 3'd2
	} plic_reg_e;

	typedef enum logic [REG_OFFSET_W-1:0] {
		SYS_DEVICE_ID = 3'd0,
		SYS_RAM_SIZE  = 3'd1,
		SYS_FREQUENCY = 3'd2,
		SYS_LEDS      = 3'd3
	} sysreg_e;

endpackage

`default_nettype wire
